/* logic/vend_pkg.sv */
package vend_pkg;

    //////////////////////////////
    // sizes and types

    localparam int NUM_ITEMS = 3;

    // 0 means no product, 1 to 3 are products
    typedef logic [1:0] item_t;
    typedef logic [1:0] pos_t;
    typedef logic [3:0] count_t;
    typedef logic [7:0] credit_t;
    typedef logic [7:0] char_t;
    // leftmost character in the top byte
    typedef logic [8*16-1:0] lcd_line_t;

    //////////////////////////////
    // menu tables, index 0 is product 1

    localparam credit_t PRICE [NUM_ITEMS] = '{8'd10, 8'd12, 8'd15};
    localparam logic [15:0] PRICE_TEXT [NUM_ITEMS] = '{"10", "12", "15"};
    localparam logic [39:0] NAME_TEXT [NUM_ITEMS] = '{"Coke ", "Water", "Juice"};
    localparam count_t INIT_STOCK [NUM_ITEMS] = '{4'd5, 4'd1, 4'd0};

    localparam count_t STOCK_LIMIT = 4'd9;
    localparam credit_t CREDIT_MAX = 8'd99;

    //////////////////////////////
    // buttons

    localparam int BTN_UP = 10;
    localparam int BTN_DOWN = 4;
    localparam int BTN_SELECT = 7;
    localparam int BTN_BUY = 9;
    localparam int BTN_RETURN = 3;
    localparam int BTN_ADD = 5;
    localparam int BTN_COIN_10 = 0;
    localparam int BTN_COIN_5 = 1;
    localparam int BTN_COIN_1 = 2;
    localparam int NUM_COINS = 3;

    // coin value by offset from BTN_COIN_10
    localparam credit_t COIN_VALUE [NUM_COINS] = '{8'd10, 8'd5, 8'd1};

    //////////////////////////////
    // timing and lcd

    // cycles per unit paid back
    localparam int RETURN_INTERVAL = 8;
    localparam int RETURN_CNT_W = $clog2(RETURN_INTERVAL);

    localparam logic [6:0] DDRAM_LINE1 = 7'h0D;
    localparam logic [6:0] DDRAM_LINE2 = 7'h4D;

endpackage

/* logic/menu_panel.sv */
module menu_panel (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic [11:0]                                   button_pulse,
    input  logic                                          admin_mode,
    input  vend_pkg::count_t [vend_pkg::NUM_ITEMS-1:0]    stock,
    input  logic                                          vend,
    output vend_pkg::pos_t                                cursor,
    output logic [6:0]                                    ddram_address,
    output vend_pkg::item_t                               selected_item,
    output logic                                          coin_strobe,
    output vend_pkg::credit_t                             coin_amount,
    output logic                                          buy_strobe,
    output logic                                          return_strobe,
    output logic                                          add_strobe
);

    logic up_press;
    logic down_press;
    logic select_press;
    logic [vend_pkg::NUM_COINS-1:0] coin_bits;
    vend_pkg::item_t cursor_item;

    assign coin_bits = button_pulse[vend_pkg::BTN_COIN_1:vend_pkg::BTN_COIN_10];
    assign cursor_item = vend_pkg::item_t'(cursor + 2'd1);

    //////////////////////////////
    // priority decode
    // move, select, coin, buy, return, add

    always_comb begin
        up_press = 1'b0;
        down_press = 1'b0;
        select_press = 1'b0;
        coin_strobe = 1'b0;
        coin_amount = '0;
        buy_strobe = 1'b0;
        return_strobe = 1'b0;
        add_strobe = 1'b0;

        if (button_pulse[vend_pkg::BTN_UP] || button_pulse[vend_pkg::BTN_DOWN]) begin
            // up wins when both are pressed
            up_press = button_pulse[vend_pkg::BTN_UP];
            down_press = !button_pulse[vend_pkg::BTN_UP];
        end else if (button_pulse[vend_pkg::BTN_SELECT]) begin
            select_press = 1'b1;
        end else if (coin_bits != '0) begin
            // two coins at once count as no coin
            coin_strobe = $onehot(coin_bits);
            for (int i = 0; i < vend_pkg::NUM_COINS; i++) begin
                if (coin_bits[i]) begin
                    coin_amount = vend_pkg::COIN_VALUE[i];
                end
            end
        end else if (button_pulse[vend_pkg::BTN_BUY]) begin
            buy_strobe = 1'b1;
        end else if (button_pulse[vend_pkg::BTN_RETURN]) begin
            return_strobe = 1'b1;
        end else if (button_pulse[vend_pkg::BTN_ADD]) begin
            add_strobe = admin_mode;
        end
    end

    //////////////////////////////
    // cursor, lcd address, selection

    always_ff @(posedge clk) begin
        if (!rst) begin
            cursor <= '0;
            ddram_address <= vend_pkg::DDRAM_LINE1;
            selected_item <= '0;
        end else begin
            if (up_press && cursor != '0) begin
                cursor <= cursor - 2'd1;
                ddram_address <= vend_pkg::DDRAM_LINE1;
            end else if (down_press && cursor != 2'(vend_pkg::NUM_ITEMS - 1)) begin
                cursor <= cursor + 2'd1;
                ddram_address <= vend_pkg::DDRAM_LINE2;
            end

            // a vend always drops the selection
            if (vend) begin
                selected_item <= '0;
            end else if (select_press) begin
                if (selected_item != '0 && selected_item == cursor_item) begin
                    selected_item <= '0;
                end else if (stock[cursor] != '0) begin
                    selected_item <= cursor_item;
                end
            end
        end
    end

    a_cursor_range: assert property (@(posedge clk) disable iff (!rst)
        cursor <= 2'(vend_pkg::NUM_ITEMS - 1));

endmodule

/* logic/stock_store.sv */
module stock_store (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          add_strobe,
    input  vend_pkg::pos_t                                cursor,
    input  logic                                          vend,
    input  vend_pkg::item_t                               vend_item,
    output vend_pkg::count_t [vend_pkg::NUM_ITEMS-1:0]    stock
);

    //////////////////////////////
    // per product counters

    // add and vend never come in the same cycle,
    // the menu decode lets only one command through
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < vend_pkg::NUM_ITEMS; i++) begin
                stock[i] <= vend_pkg::INIT_STOCK[i];
            end
        end else begin
            for (int i = 0; i < vend_pkg::NUM_ITEMS; i++) begin
                if (add_strobe && cursor == vend_pkg::pos_t'(i)) begin
                    // restock stops at the ceiling
                    if (stock[i] < vend_pkg::STOCK_LIMIT) begin
                        stock[i] <= stock[i] + 4'd1;
                    end
                end else if (vend && vend_item == vend_pkg::item_t'(i + 1)) begin
                    if (stock[i] != '0) begin
                        stock[i] <= stock[i] - 4'd1;
                    end
                end
            end
        end
    end

    //////////////////////////////
    // checks

    for (genvar g = 0; g < vend_pkg::NUM_ITEMS; g++) begin : g_limit
        a_stock_limit: assert property (@(posedge clk) disable iff (!rst)
            stock[g] <= vend_pkg::STOCK_LIMIT);
    end

endmodule

/* logic/credit_ledger.sv */
module credit_ledger (
    input  logic                                          clk,
    input  logic                                          rst,
    input  logic                                          coin_strobe,
    input  vend_pkg::credit_t                             coin_amount,
    input  logic                                          buy_strobe,
    input  vend_pkg::item_t                               selected_item,
    input  logic                                          return_strobe,
    input  vend_pkg::count_t [vend_pkg::NUM_ITEMS-1:0]    stock,
    output vend_pkg::credit_t                             credit,
    output logic                                          vend,
    output vend_pkg::item_t                               vend_item
);

    localparam int CNT_W = vend_pkg::RETURN_CNT_W;
    localparam logic [CNT_W-1:0] TICK_LAST = CNT_W'(vend_pkg::RETURN_INTERVAL - 1);

    logic returning;
    logic [CNT_W-1:0] tick_cnt;
    logic [8:0] coin_sum;
    logic [1:0] sel_idx;
    vend_pkg::credit_t sel_price;

    // table index of the selected product
    assign sel_idx = (selected_item == '0) ? 2'd0 : 2'(selected_item - 2'd1);
    assign sel_price = vend_pkg::PRICE[sel_idx];

    // one extra bit so an overflowing coin is seen
    assign coin_sum = {1'b0, credit} + {1'b0, coin_amount};

    //////////////////////////////
    // buy decision
    // credit has to be strictly above the price

    assign vend = buy_strobe && !returning && selected_item != '0 &&
                  stock[sel_idx] != '0 && credit > sel_price;
    assign vend_item = vend ? selected_item : '0;

    //////////////////////////////
    // credit and return countdown

    always_ff @(posedge clk) begin
        if (!rst) begin
            credit <= '0;
            returning <= 1'b0;
            tick_cnt <= '0;
        end else if (returning) begin
            // coins and buys are dropped here
            if (credit == '0) begin
                returning <= 1'b0;
            end else if (tick_cnt == TICK_LAST) begin
                tick_cnt <= '0;
                credit <= credit - 8'd1;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end else begin
            if (coin_strobe) begin
                if (coin_sum <= {1'b0, vend_pkg::CREDIT_MAX}) begin
                    credit <= coin_sum[7:0];
                end
            end else if (vend) begin
                credit <= credit - sel_price;
            end else if (return_strobe && credit != '0) begin
                returning <= 1'b1;
                tick_cnt <= '0;
            end
        end
    end

    //////////////////////////////
    // checks

    a_credit_max: assert property (@(posedge clk) disable iff (!rst)
        credit <= vend_pkg::CREDIT_MAX);

    a_vend_single: assert property (@(posedge clk) disable iff (!rst)
        vend |=> !vend);

endmodule

/* logic/lcd_line_builder.sv */
module lcd_line_builder #(
    parameter vend_pkg::char_t EDGE_CHAR = "^"
) (
    input  vend_pkg::item_t                               item,
    input  vend_pkg::item_t                               selected_item,
    input  vend_pkg::count_t [vend_pkg::NUM_ITEMS-1:0]    stock,
    input  logic                                          admin_mode,
    output vend_pkg::lcd_line_t                           text
);

    logic [1:0] idx;
    vend_pkg::count_t item_stock;
    vend_pkg::char_t digit_char;
    vend_pkg::char_t mark_char;
    vend_pkg::char_t stock_char;

    //////////////////////////////
    // per item fields

    // item 0 falls back to the first table entry
    assign idx = (item == '0) ? 2'd0 : 2'(item - 2'd1);
    assign item_stock = stock[idx];

    // menu number as ascii digit
    assign digit_char = 8'h30 + {6'd0, item};

    always_comb begin
        if (item != '0 && item == selected_item) begin
            mark_char = "*";
        end else begin
            mark_char = " ";
        end

        // admin sees the count, customers only see sold out
        if (admin_mode) begin
            stock_char = 8'h30 + {4'd0, item_stock};
        end else if (item_stock == '0) begin
            stock_char = "X";
        end else begin
            stock_char = " ";
        end
    end

    //////////////////////////////
    // line layout
    // byte 15 digit, 14 dot, 13..9 name, 8 space,
    // 7..6 price, 5..3 "00W", 2 mark, 1 stock, 0 edge

    assign text = {
        digit_char,
        ".",
        vend_pkg::NAME_TEXT[idx],
        " ",
        vend_pkg::PRICE_TEXT[idx],
        "00W",
        mark_char,
        stock_char,
        EDGE_CHAR
    };

endmodule

/* logic/vending_top.sv */
module vending_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [11:0]             button_pulse,
    input  logic                    admin_mode,
    output vend_pkg::credit_t       display_credit,
    output vend_pkg::count_t        stock_at_cursor,
    output vend_pkg::lcd_line_t     line1_text,
    output vend_pkg::lcd_line_t     line2_text,
    output logic [6:0]              ddram_address
);

    vend_pkg::pos_t cursor;
    vend_pkg::item_t selected_item;
    logic coin_strobe;
    vend_pkg::credit_t coin_amount;
    logic buy_strobe;
    logic return_strobe;
    logic add_strobe;
    vend_pkg::count_t [vend_pkg::NUM_ITEMS-1:0] stock;
    vend_pkg::credit_t credit;
    logic vend;
    vend_pkg::item_t vend_item;
    logic show_upper;
    vend_pkg::item_t line1_item;
    vend_pkg::item_t line2_item;

    //////////////////////////////
    // control path

    menu_panel u_menu_panel (
        .clk           (clk),
        .rst           (rst),
        .button_pulse  (button_pulse),
        .admin_mode    (admin_mode),
        .stock         (stock),
        .vend          (vend),
        .cursor        (cursor),
        .ddram_address (ddram_address),
        .selected_item (selected_item),
        .coin_strobe   (coin_strobe),
        .coin_amount   (coin_amount),
        .buy_strobe    (buy_strobe),
        .return_strobe (return_strobe),
        .add_strobe    (add_strobe)
    );

    stock_store u_stock_store (
        .clk        (clk),
        .rst        (rst),
        .add_strobe (add_strobe),
        .cursor     (cursor),
        .vend       (vend),
        .vend_item  (vend_item),
        .stock      (stock)
    );

    credit_ledger u_credit_ledger (
        .clk           (clk),
        .rst           (rst),
        .coin_strobe   (coin_strobe),
        .coin_amount   (coin_amount),
        .buy_strobe    (buy_strobe),
        .selected_item (selected_item),
        .return_strobe (return_strobe),
        .stock         (stock),
        .credit        (credit),
        .vend          (vend),
        .vend_item     (vend_item)
    );

    //////////////////////////////
    // display window

    // cursor 1 on the lower line still shows items 1 and 2
    assign show_upper = (cursor == 2'd0) ||
                        (cursor == 2'd1 && ddram_address == vend_pkg::DDRAM_LINE2);
    assign line1_item = show_upper ? 2'd1 : 2'd2;
    assign line2_item = show_upper ? 2'd2 : 2'd3;

    lcd_line_builder #(.EDGE_CHAR("^")) u_line1 (
        .item          (line1_item),
        .selected_item (selected_item),
        .stock         (stock),
        .admin_mode    (admin_mode),
        .text          (line1_text)
    );

    lcd_line_builder #(.EDGE_CHAR("v")) u_line2 (
        .item          (line2_item),
        .selected_item (selected_item),
        .stock         (stock),
        .admin_mode    (admin_mode),
        .text          (line2_text)
    );

    assign display_credit = credit;
    assign stock_at_cursor = stock[cursor];

endmodule

/* verification/vending_steps.svh */
// each row is applied as reps one-cycle button pulses
// columns are button, reps, admin_mode, then the expected display_credit,
// stock_at_cursor, ddram_address, line1 mark, line1 stock char, line2 first digit
// and line2 mark

// power-up view, coins, cursor moves
add_step(NO_BTN,                1, 1'b0, 8'd0,  4'd5, 7'h0D, " ", " ", "2", " ");
add_step(vend_pkg::BTN_COIN_10, 1, 1'b0, 8'd10, 4'd5, 7'h0D, " ", " ", "2", " ");
add_step(vend_pkg::BTN_COIN_5,  1, 1'b0, 8'd15, 4'd5, 7'h0D, " ", " ", "2", " ");
add_step(vend_pkg::BTN_COIN_1,  1, 1'b0, 8'd16, 4'd5, 7'h0D, " ", " ", "2", " ");
add_step(vend_pkg::BTN_UP,      1, 1'b0, 8'd16, 4'd5, 7'h0D, " ", " ", "2", " ");
add_step(vend_pkg::BTN_DOWN,    1, 1'b0, 8'd16, 4'd1, 7'h4D, " ", " ", "2", " ");
add_step(vend_pkg::BTN_DOWN,    1, 1'b0, 8'd16, 4'd0, 7'h4D, " ", " ", "3", " ");
add_step(vend_pkg::BTN_DOWN,    1, 1'b0, 8'd16, 4'd0, 7'h4D, " ", " ", "3", " ");
// juice is sold out so select does nothing
add_step(vend_pkg::BTN_SELECT,  1, 1'b0, 8'd16, 4'd0, 7'h4D, " ", " ", "3", " ");
add_step(vend_pkg::BTN_UP,      1, 1'b0, 8'd16, 4'd1, 7'h0D, " ", " ", "3", " ");
add_step(vend_pkg::BTN_UP,      1, 1'b0, 8'd16, 4'd5, 7'h0D, " ", " ", "2", " ");
// select toggles on coke, then buy it
add_step(vend_pkg::BTN_SELECT,  1, 1'b0, 8'd16, 4'd5, 7'h0D, "*", " ", "2", " ");
add_step(vend_pkg::BTN_SELECT,  1, 1'b0, 8'd16, 4'd5, 7'h0D, " ", " ", "2", " ");
add_step(vend_pkg::BTN_SELECT,  1, 1'b0, 8'd16, 4'd5, 7'h0D, "*", " ", "2", " ");
add_step(vend_pkg::BTN_BUY,     1, 1'b0, 8'd6,  4'd4, 7'h0D, " ", " ", "2", " ");
// water with too little credit, then with exactly the price
add_step(vend_pkg::BTN_DOWN,    1, 1'b0, 8'd6,  4'd1, 7'h4D, " ", " ", "2", " ");
add_step(vend_pkg::BTN_SELECT,  1, 1'b0, 8'd6,  4'd1, 7'h4D, " ", " ", "2", "*");
add_step(vend_pkg::BTN_DOWN,    1, 1'b0, 8'd6,  4'd0, 7'h4D, "*", " ", "3", " ");
add_step(vend_pkg::BTN_BUY,     1, 1'b0, 8'd6,  4'd0, 7'h4D, "*", " ", "3", " ");
add_step(vend_pkg::BTN_COIN_5,  1, 1'b0, 8'd11, 4'd0, 7'h4D, "*", " ", "3", " ");
add_step(vend_pkg::BTN_COIN_1,  1, 1'b0, 8'd12, 4'd0, 7'h4D, "*", " ", "3", " ");
add_step(vend_pkg::BTN_BUY,     1, 1'b0, 8'd12, 4'd0, 7'h4D, "*", " ", "3", " ");
// fill up, the coin past 99 is dropped, then water sells out
add_step(vend_pkg::BTN_COIN_10, 8, 1'b0, 8'd92, 4'd0, 7'h4D, "*", " ", "3", " ");
add_step(vend_pkg::BTN_COIN_10, 1, 1'b0, 8'd92, 4'd0, 7'h4D, "*", " ", "3", " ");
add_step(vend_pkg::BTN_BUY,     1, 1'b0, 8'd80, 4'd0, 7'h4D, " ", "X", "3", " ");
// pay back everything
add_step(vend_pkg::BTN_RETURN,  1, 1'b0, 8'd0,  4'd0, 7'h4D, " ", "X", "3", " ");
add_step(NO_BTN,                1, 1'b0, 8'd0,  4'd0, 7'h4D, " ", "X", "3", " ");
// admin view and restock
add_step(NO_BTN,                1, 1'b1, 8'd0,  4'd0, 7'h4D, " ", "0", "3", " ");
add_step(vend_pkg::BTN_ADD,     1, 1'b0, 8'd0,  4'd0, 7'h4D, " ", "X", "3", " ");
add_step(vend_pkg::BTN_ADD,     1, 1'b1, 8'd0,  4'd1, 7'h4D, " ", "0", "3", " ");
add_step(vend_pkg::BTN_ADD,     8, 1'b1, 8'd0,  4'd9, 7'h4D, " ", "0", "3", " ");
add_step(vend_pkg::BTN_ADD,     1, 1'b1, 8'd0,  4'd9, 7'h4D, " ", "0", "3", " ");
add_step(vend_pkg::BTN_UP,      1, 1'b1, 8'd0,  4'd0, 7'h0D, " ", "0", "3", " ");
add_step(vend_pkg::BTN_UP,      1, 1'b1, 8'd0,  4'd4, 7'h0D, " ", "4", "2", " ");
add_step(vend_pkg::BTN_ADD,     1, 1'b1, 8'd0,  4'd5, 7'h0D, " ", "5", "2", " ");
add_step(NO_BTN,                1, 1'b0, 8'd0,  4'd5, 7'h0D, " ", " ", "2", " ");
add_step(vend_pkg::BTN_COIN_1,  1, 1'b0, 8'd1,  4'd5, 7'h0D, " ", " ", "2", " ");

/* verification/vending_tb.sv */
module vending_tb;

    localparam int NO_BTN = -1;
    // worst case per row is a full return from the top credit
    localparam int STEP_BUDGET =
        vend_pkg::RETURN_INTERVAL * int'(vend_pkg::CREDIT_MAX) + 4;

    typedef struct packed {
        int btn;
        int reps;
        logic admin;
        vend_pkg::credit_t credit;
        vend_pkg::count_t stock;
        logic [6:0] addr;
        vend_pkg::char_t mark;
        vend_pkg::char_t stock_char;
        vend_pkg::char_t digit;
        vend_pkg::char_t mark2;
    } step_t;

    logic clk = 1'b0;
    logic rst;
    logic [11:0] button_pulse;
    logic admin_mode;
    vend_pkg::credit_t display_credit;
    vend_pkg::count_t stock_at_cursor;
    vend_pkg::lcd_line_t line1_text;
    vend_pkg::lcd_line_t line2_text;
    logic [6:0] ddram_address;

    step_t steps[$];
    int error_count = 0;
    int checks_done = 0;
    int cycle_count = 0;
    int timeout_limit = 0;

    vending_top u_dut (
        .clk             (clk),
        .rst             (rst),
        .button_pulse    (button_pulse),
        .admin_mode      (admin_mode),
        .display_credit  (display_credit),
        .stock_at_cursor (stock_at_cursor),
        .line1_text      (line1_text),
        .line2_text      (line2_text),
        .ddram_address   (ddram_address)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //////////////////////////////
    // helpers

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks_done++;
        if (actual !== expected) begin
            error_count++;
            $display("ERR time %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic add_step(input int btn, input int reps, input logic admin,
                            input vend_pkg::credit_t credit, input vend_pkg::count_t stock,
                            input logic [6:0] addr, input vend_pkg::char_t mark,
                            input vend_pkg::char_t stock_char, input vend_pkg::char_t digit,
                            input vend_pkg::char_t mark2);
        steps.push_back(step_t'{btn, reps, admin, credit, stock, addr, mark, stock_char, digit,
                                mark2});
    endtask

    task automatic load_steps();
        `include "vending_steps.svh"
    endtask

    // credit falls by one every interval and coins in between are dropped
    task automatic follow_return();
        vend_pkg::credit_t prev;
        int since;
        prev = display_credit;
        since = 0;
        while (display_credit != '0) begin
            if (since == 3) begin
                button_pulse = 12'd1 << vend_pkg::BTN_COIN_5;
            end
            @(negedge clk);
            button_pulse = '0;
            since++;
            if (display_credit != prev) begin
                check_value("return interval", vend_pkg::RETURN_INTERVAL, since);
                check_value("display_credit", prev - 8'd1, display_credit);
                prev = display_credit;
                since = 0;
            end
        end
    endtask

    task automatic run_step(input step_t s);
        admin_mode = s.admin;
        for (int r = 0; r < s.reps; r++) begin
            if (s.btn != NO_BTN) begin
                button_pulse = 12'd1 << s.btn;
            end
            @(posedge clk);
            @(negedge clk);
            button_pulse = '0;
        end
        if (s.btn == vend_pkg::BTN_RETURN) begin
            follow_return();
        end
    endtask

    task automatic verify_row(input int row, input step_t s);
        check_value($sformatf("display_credit (row %0d)", row), s.credit, display_credit);
        check_value($sformatf("stock_at_cursor (row %0d)", row), s.stock, stock_at_cursor);
        check_value($sformatf("ddram_address (row %0d)", row), s.addr, ddram_address);
        check_value($sformatf("line1_text mark (row %0d)", row), s.mark, line1_text[23:16]);
        check_value($sformatf("line1_text stock (row %0d)", row), s.stock_char, line1_text[15:8]);
        check_value($sformatf("line2_text digit (row %0d)", row), s.digit, line2_text[127:120]);
        check_value($sformatf("line2_text mark (row %0d)", row), s.mark2, line2_text[23:16]);
    endtask

    //////////////////////////////
    // main sequence

    initial begin
        rst = 1'b0;
        button_pulse = '0;
        admin_mode = 1'b0;
        load_steps();
        timeout_limit = steps.size() * STEP_BUDGET;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        // power-up screen
        check_value("line1_text", "1.Coke  1000W  ^", line1_text);
        check_value("line2_text", "2.Water 1200W  v", line2_text);

        for (int i = 0; i < steps.size(); i++) begin
            run_step(steps[i]);
            verify_row(i, steps[i]);
        end

        $display("checks %0d, errors %0d", checks_done, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+verification
logic/vend_pkg.sv
logic/menu_panel.sv
logic/stock_store.sv
logic/credit_ledger.sv
logic/lcd_line_builder.sv
logic/vending_top.sv
verification/vending_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the vending testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module vending_tb --Mdir obj_dir -o vending_sim &&
    ./obj_dir/vending_sim | tee /dev/stderr | grep -F -- "*** TEST PASSED ***" > /dev/null &&
    echo "run_sim: simulation passed" ||
    { echo "run_sim: simulation failed"; exit 1; }
